// ==== common/kdi_pkg.sv ====
// Shared widths, commands and request bundles of the OTP scrambling key derivation block
package kdi_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One digest block
  parameter int ScrmblBlockWidth = 64;
  // One EDN word, same as a digest block
  parameter int EdnDataWidth     = 64;
  // Derived key, two digest results
  parameter int KeyWidth         = 128;
  // Flash seed, SRAM seed is half of it
  parameter int SeedWidth        = 256;
  parameter int NumSeedBlocks    = SeedWidth / ScrmblBlockWidth;
  // Nonce words kept in the output register
  parameter int NumNonceChunks   = 2;
  // Seed and entropy counters
  parameter int CntWidth         = 2;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // Netlist constant index for the digest
  typedef enum logic [1:0] {
    FlashDataKey = 2'd0,
    FlashAddrKey = 2'd1,
    SramDataKey  = 2'd2
  } digest_sel_e;

  // Digest datapath commands
  typedef enum logic [1:0] {
    LoadShadow     = 2'd0,
    DigestInit     = 2'd1,
    Digest         = 2'd2,
    DigestFinalize = 2'd3
  } scrmbl_cmd_e;

  // Source of the digest input block
  typedef enum logic {
    SeedData    = 1'b0,
    EntropyData = 1'b1
  } data_sel_e;

  //////////////////////////////////////////////////
  // Bundles
  //////////////////////////////////////////////////

  // Configuration of one derivation request
  typedef struct packed {
    logic                                          ingest_entropy;
    digest_sel_e                                   digest_sel;
    // Nonce words to fetch, minus one
    logic [1:0]                                    nonce_size;
    logic                                          seed_valid;
    logic [NumSeedBlocks-1:0][ScrmblBlockWidth-1:0] seed;
  } req_bundle_t;

  // Command towards the digest datapath
  typedef struct packed {
    logic                        valid;
    scrmbl_cmd_e                 cmd;
    digest_sel_e                 sel;
    logic [ScrmblBlockWidth-1:0] data;
  } scrmbl_req_t;

  // Response to one client
  typedef struct packed {
    logic                                        ack;
    logic [KeyWidth-1:0]                         key;
    logic [NumNonceChunks-1:0][EdnDataWidth-1:0] nonce;
    logic                                        seed_valid;
  } key_rsp_t;

endpackage

// ==== kdi/kdi_req_arbiter.sv ====
// Round-robin arbiter that maps key requests to derivation configuration bundles
`timescale 1ns/1ps

module kdi_req_arbiter #(
  parameter int NumSramSlots = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Client request levels
  input  logic                                 flash_data_req_i,
  input  logic                                 flash_addr_req_i,
  input  logic [NumSramSlots-1:0]              sram_req_i,
  // Seeds from OTP
  input  logic                                 seed_valid_i,
  input  logic [kdi_pkg::SeedWidth-1:0]        flash_data_seed_i,
  input  logic [kdi_pkg::SeedWidth-1:0]        flash_addr_seed_i,
  input  logic [kdi_pkg::SeedWidth/2-1:0]      sram_seed_i,
  // FSM side
  input  logic                                 req_ready_i,
  output logic                                 req_valid_o,
  output kdi_pkg::req_bundle_t                 req_bundle_o,
  output logic [NumSramSlots+1:0]              ack_o
);

  // Two flash keys, then the SRAM slots
  localparam int NumReq = NumSramSlots + 2;
  localparam int IdxW   = $clog2(NumReq);

  logic [NumReq-1:0]    req;
  kdi_pkg::req_bundle_t bundles [NumReq];
  logic [IdxW-1:0]      ptr_q, idx_q, pick_idx;
  logic                 locked_q, pick_valid;

  assign req = {sram_req_i, flash_addr_req_i, flash_data_req_i};

  //////////////////////////////////////////////////
  // Request bundles
  //////////////////////////////////////////////////

  // Flash data key, plain seed digest and two nonce words
  assign bundles[0] = '{ingest_entropy: 1'b0,
                        digest_sel:     kdi_pkg::FlashDataKey,
                        nonce_size:     2'd1,
                        seed_valid:     seed_valid_i,
                        seed:           flash_data_seed_i};
  // Flash address key, only one nonce word
  assign bundles[1] = '{ingest_entropy: 1'b0,
                        digest_sel:     kdi_pkg::FlashAddrKey,
                        nonce_size:     2'd0,
                        seed_valid:     seed_valid_i,
                        seed:           flash_addr_seed_i};

  // SRAM slots mix in entropy, seed is used twice
  for (genvar k = 2; k < NumReq; k++) begin : gen_sram_bundle
    assign bundles[k] = '{ingest_entropy: 1'b1,
                          digest_sel:     kdi_pkg::SramDataKey,
                          nonce_size:     2'd1,
                          seed_valid:     seed_valid_i,
                          seed:           {sram_seed_i, sram_seed_i}};
  end

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  // First requester at or after the pointer
  always_comb begin : p_pick
    int unsigned cand;
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int unsigned off = 0; off < NumReq; off++) begin
      cand = (int'(ptr_q) + off) % NumReq;
      if (!pick_valid && req[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = IdxW'(cand);
      end
    end
  end

  // Held choice wins over a fresh pick
  assign req_valid_o  = locked_q | pick_valid;
  assign req_bundle_o = locked_q ? bundles[idx_q] : bundles[pick_idx];

  // Ack pulse goes to the held winner
  for (genvar k = 0; k < NumReq; k++) begin : gen_ack
    assign ack_o[k] = req_ready_i && locked_q && (idx_q == IdxW'(k));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q    <= '0;
      idx_q    <= '0;
      locked_q <= 1'b0;
    end else if (locked_q) begin
      if (req_ready_i) begin
        locked_q <= 1'b0;
        // Move past the winner
        ptr_q    <= (idx_q == IdxW'(NumReq - 1)) ? '0 : idx_q + 1'b1;
      end
    end else if (pick_valid) begin
      locked_q <= 1'b1;
      idx_q    <= pick_idx;
    end
  end

endmodule

// ==== kdi/kdi_fsm.sv ====
// Control FSM that sequences digest, EDN and mutex for each key derivation
`timescale 1ns/1ps

module kdi_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            kdi_en_i,
  input  logic                            escalate_en_i,
  // Arbiter side
  input  logic                            req_valid_i,
  input  kdi_pkg::req_bundle_t            req_bundle_i,
  output logic                            req_ready_o,
  // EDN
  output logic                            edn_req_o,
  input  logic                            edn_ack_i,
  // Digest mutex and datapath
  output logic                            scrmbl_mtx_req_o,
  input  logic                            scrmbl_mtx_gnt_i,
  input  logic                            scrmbl_ready_i,
  input  logic                            scrmbl_valid_i,
  output logic                            fsm_err_o,
  // Register control
  output logic                            key_we_o,
  output logic                            nonce_we_o,
  output logic                            seed_valid_we_o,
  output kdi_pkg::data_sel_e              data_sel_o,
  output logic [kdi_pkg::CntWidth-1:0]    seed_cnt_o,
  output logic [kdi_pkg::CntWidth-1:0]    entropy_cnt_o,
  output kdi_pkg::scrmbl_cmd_e            scrmbl_cmd_o,
  output logic                            scrmbl_valid_o
);

  typedef enum logic [3:0] {
    ResetSt,
    IdleSt,
    DigClrSt,
    DigLoadSt,
    FetchEntropySt,
    DigEntropySt,
    DigFinSt,
    DigWaitSt,
    FetchNonceSt,
    FinishSt,
    ErrorSt
  } state_e;

  state_e                        state_d, state_q;
  logic [kdi_pkg::CntWidth-1:0]  seed_cnt_q, entropy_cnt_q;
  logic                          seed_cnt_clr, seed_cnt_en;
  logic                          entropy_cnt_clr, entropy_cnt_en;
  logic                          edn_req_d, edn_req_q;

  assign edn_req_o     = edn_req_q;
  assign seed_cnt_o    = seed_cnt_q;
  assign entropy_cnt_o = entropy_cnt_q;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d          = state_q;
    fsm_err_o        = 1'b0;
    seed_cnt_clr     = 1'b0;
    seed_cnt_en      = 1'b0;
    entropy_cnt_clr  = 1'b0;
    entropy_cnt_en   = 1'b0;
    // Open EDN request stays up until acked
    edn_req_d        = edn_req_q & ~edn_ack_i;
    data_sel_o       = kdi_pkg::SeedData;
    key_we_o         = 1'b0;
    nonce_we_o       = 1'b0;
    seed_valid_we_o  = 1'b0;
    scrmbl_mtx_req_o = 1'b0;
    scrmbl_cmd_o     = kdi_pkg::LoadShadow;
    scrmbl_valid_o   = 1'b0;
    req_ready_o      = 1'b0;

    unique case (state_q)
      // Wait for the enable pulse after OTP init
      ResetSt: begin
        if (kdi_en_i) state_d = IdleSt;
      end
      IdleSt: begin
        if (req_valid_i) begin
          state_d         = DigClrSt;
          seed_cnt_clr    = 1'b1;
          entropy_cnt_clr = 1'b1;
        end
      end
      // Take the mutex and reset the digest to its IV
      DigClrSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        scrmbl_cmd_o     = kdi_pkg::DigestInit;
        if (scrmbl_mtx_gnt_i && scrmbl_ready_i) state_d = DigLoadSt;
      end
      // Even block is loaded, odd block triggers the round
      DigLoadSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        if (seed_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d = req_bundle_i.ingest_entropy ? FetchEntropySt : DigFinSt;
          end
        end else if (scrmbl_ready_i) begin
          seed_cnt_en = 1'b1;
        end
      end
      // Two EDN words into the nonce register
      FetchEntropySt: begin
        scrmbl_mtx_req_o = 1'b1;
        edn_req_d        = 1'b1;
        if (edn_ack_i) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == kdi_pkg::CntWidth'(1)) begin
            state_d         = DigEntropySt;
            entropy_cnt_clr = 1'b1;
            edn_req_d       = 1'b0;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      // Same load/digest pair, this time on the entropy words
      DigEntropySt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        data_sel_o       = kdi_pkg::EntropyData;
        if (entropy_cnt_q[0]) begin
          scrmbl_cmd_o = kdi_pkg::Digest;
          if (scrmbl_ready_i) begin
            state_d         = DigFinSt;
            entropy_cnt_clr = 1'b1;
          end
        end else if (scrmbl_ready_i) begin
          entropy_cnt_en = 1'b1;
        end
      end
      DigFinSt: begin
        scrmbl_mtx_req_o = 1'b1;
        scrmbl_valid_o   = 1'b1;
        scrmbl_cmd_o     = kdi_pkg::DigestFinalize;
        if (scrmbl_ready_i) state_d = DigWaitSt;
      end
      // Result lands in key half seed_cnt[1]
      DigWaitSt: begin
        scrmbl_mtx_req_o = 1'b1;
        if (scrmbl_valid_i) begin
          key_we_o = 1'b1;
          if (seed_cnt_q == kdi_pkg::CntWidth'(1)) begin
            // Upper seed half still to go
            seed_cnt_en = 1'b1;
            state_d     = DigClrSt;
          end else begin
            seed_cnt_clr    = 1'b1;
            seed_valid_we_o = 1'b1;
            state_d         = FetchNonceSt;
          end
        end
      end
      // Mutex already released here
      FetchNonceSt: begin
        edn_req_d = 1'b1;
        if (edn_ack_i) begin
          nonce_we_o = 1'b1;
          if (entropy_cnt_q == req_bundle_i.nonce_size) begin
            state_d         = FinishSt;
            entropy_cnt_clr = 1'b1;
            edn_req_d       = 1'b0;
          end else begin
            entropy_cnt_en = 1'b1;
          end
        end
      end
      FinishSt: begin
        req_ready_o = 1'b1;
        state_d     = IdleSt;
      end
      // Terminal
      ErrorSt: fsm_err_o = 1'b1;
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation overrides everything
    if (escalate_en_i) state_d = ErrorSt;
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ResetSt;
      edn_req_q     <= 1'b0;
      seed_cnt_q    <= '0;
      entropy_cnt_q <= '0;
    end else begin
      state_q   <= state_d;
      edn_req_q <= edn_req_d;
      // Clear has priority over count
      if (seed_cnt_clr) seed_cnt_q <= '0;
      else if (seed_cnt_en) seed_cnt_q <= seed_cnt_q + 1'b1;
      if (entropy_cnt_clr) entropy_cnt_q <= '0;
      else if (entropy_cnt_en) entropy_cnt_q <= entropy_cnt_q + 1'b1;
    end
  end

endmodule

// ==== kdi/kdi_key_regs.sv ====
// Key, nonce and seed-valid output registers with the digest input mux
`timescale 1ns/1ps

module kdi_key_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   key_we_i,
  input  logic                                   nonce_we_i,
  input  logic                                   seed_valid_we_i,
  input  kdi_pkg::data_sel_e                     data_sel_i,
  input  logic [kdi_pkg::CntWidth-1:0]           seed_cnt_i,
  input  logic [kdi_pkg::CntWidth-1:0]           entropy_cnt_i,
  input  kdi_pkg::req_bundle_t                   req_bundle_i,
  input  logic [kdi_pkg::ScrmblBlockWidth-1:0]   scrmbl_data_i,
  input  logic [kdi_pkg::EdnDataWidth-1:0]       edn_data_i,
  output logic [kdi_pkg::ScrmblBlockWidth-1:0]   scrmbl_data_o,
  output logic [kdi_pkg::KeyWidth-1:0]           key_o,
  output logic [kdi_pkg::NumNonceChunks-1:0][kdi_pkg::EdnDataWidth-1:0] nonce_o,
  output logic                                   seed_valid_o
);

  localparam int NumKeyHalves = kdi_pkg::KeyWidth / kdi_pkg::ScrmblBlockWidth;
  localparam int NonceIdxW    = $clog2(kdi_pkg::NumNonceChunks);

  logic [NumKeyHalves-1:0][kdi_pkg::ScrmblBlockWidth-1:0]          key_q;
  logic [kdi_pkg::NumNonceChunks-1:0][kdi_pkg::EdnDataWidth-1:0]  nonce_q;
  logic                                                            seed_valid_q;

  // Entropy words come back from the nonce register
  // Invalid seeds feed zero blocks
  assign scrmbl_data_o = (data_sel_i == kdi_pkg::EntropyData) ? nonce_q[entropy_cnt_i[0]] :
                         req_bundle_i.seed_valid ? req_bundle_i.seed[seed_cnt_i] : '0;

  assign key_o        = key_q;
  assign nonce_o      = nonce_q;
  assign seed_valid_o = seed_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q        <= '0;
      nonce_q      <= '0;
      seed_valid_q <= 1'b0;
    end else begin
      // Upper seed half gives the upper key half
      if (key_we_i) key_q[seed_cnt_i[1]] <= scrmbl_data_i;
      if (nonce_we_i) nonce_q[entropy_cnt_i[NonceIdxW-1:0]] <= edn_data_i;
      if (seed_valid_we_i) seed_valid_q <= req_bundle_i.seed_valid;
    end
  end

endmodule

// ==== verilog/kdi_top.sv ====
// Top level of the key derivation block joining arbiter, FSM and output registers
`timescale 1ns/1ps

module kdi_top #(
  parameter int NumSramSlots = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   kdi_en_i,
  input  logic                                   escalate_en_i,
  output logic                                   fsm_err_o,
  // Seeds
  input  logic                                   seed_valid_i,
  input  logic [kdi_pkg::SeedWidth-1:0]          flash_data_seed_i,
  input  logic [kdi_pkg::SeedWidth-1:0]          flash_addr_seed_i,
  input  logic [kdi_pkg::SeedWidth/2-1:0]        sram_seed_i,
  // Clients
  input  logic                                   flash_data_req_i,
  input  logic                                   flash_addr_req_i,
  input  logic [NumSramSlots-1:0]                sram_req_i,
  output kdi_pkg::key_rsp_t                      flash_data_rsp_o,
  output kdi_pkg::key_rsp_t                      flash_addr_rsp_o,
  output kdi_pkg::key_rsp_t [NumSramSlots-1:0]   sram_rsp_o,
  // EDN
  output logic                                   edn_req_o,
  input  logic                                   edn_ack_i,
  input  logic [kdi_pkg::EdnDataWidth-1:0]       edn_data_i,
  // Digest mutex and datapath
  output logic                                   scrmbl_mtx_req_o,
  input  logic                                   scrmbl_mtx_gnt_i,
  output kdi_pkg::scrmbl_req_t                   scrmbl_req_o,
  input  logic                                   scrmbl_ready_i,
  input  logic                                   scrmbl_valid_i,
  input  logic [kdi_pkg::ScrmblBlockWidth-1:0]   scrmbl_data_i
);

  logic                                 req_valid, req_ready;
  kdi_pkg::req_bundle_t                 req_bundle;
  logic [NumSramSlots+1:0]              ack;
  logic                                 key_we, nonce_we, seed_valid_we;
  kdi_pkg::data_sel_e                   data_sel;
  logic [kdi_pkg::CntWidth-1:0]         seed_cnt, entropy_cnt;
  kdi_pkg::scrmbl_cmd_e                 scrmbl_cmd;
  logic                                 scrmbl_valid;
  logic [kdi_pkg::ScrmblBlockWidth-1:0] scrmbl_data;
  logic [kdi_pkg::KeyWidth-1:0]         key;
  logic [kdi_pkg::NumNonceChunks-1:0][kdi_pkg::EdnDataWidth-1:0] nonce;
  logic                                 seed_valid;

  kdi_req_arbiter #(
    .NumSramSlots(NumSramSlots)
  ) u_arbiter (
    .clk_i, .rst_ni, .flash_data_req_i, .flash_addr_req_i, .sram_req_i,
    .seed_valid_i, .flash_data_seed_i, .flash_addr_seed_i, .sram_seed_i,
    .req_ready_i(req_ready), .req_valid_o(req_valid), .req_bundle_o(req_bundle),
    .ack_o(ack)
  );

  kdi_fsm u_fsm (
    .clk_i, .rst_ni, .kdi_en_i, .escalate_en_i,
    .req_valid_i(req_valid), .req_bundle_i(req_bundle), .req_ready_o(req_ready),
    .edn_req_o, .edn_ack_i, .scrmbl_mtx_req_o, .scrmbl_mtx_gnt_i,
    .scrmbl_ready_i, .scrmbl_valid_i, .fsm_err_o,
    .key_we_o(key_we), .nonce_we_o(nonce_we), .seed_valid_we_o(seed_valid_we),
    .data_sel_o(data_sel), .seed_cnt_o(seed_cnt), .entropy_cnt_o(entropy_cnt),
    .scrmbl_cmd_o(scrmbl_cmd), .scrmbl_valid_o(scrmbl_valid)
  );

  kdi_key_regs u_key_regs (
    .clk_i, .rst_ni,
    .key_we_i(key_we), .nonce_we_i(nonce_we), .seed_valid_we_i(seed_valid_we),
    .data_sel_i(data_sel), .seed_cnt_i(seed_cnt), .entropy_cnt_i(entropy_cnt),
    .req_bundle_i(req_bundle), .scrmbl_data_i, .edn_data_i,
    .scrmbl_data_o(scrmbl_data), .key_o(key), .nonce_o(nonce), .seed_valid_o(seed_valid)
  );

  // Digest command, sel follows the granted bundle
  assign scrmbl_req_o = '{valid: scrmbl_valid, cmd: scrmbl_cmd,
                          sel: req_bundle.digest_sel, data: scrmbl_data};

  // All clients share the output registers
  assign flash_data_rsp_o = '{ack: ack[0], key: key, nonce: nonce, seed_valid: seed_valid};
  assign flash_addr_rsp_o = '{ack: ack[1], key: key, nonce: nonce, seed_valid: seed_valid};
  for (genvar k = 0; k < NumSramSlots; k++) begin : gen_sram_rsp
    assign sram_rsp_o[k] = '{ack: ack[k+2], key: key, nonce: nonce, seed_valid: seed_valid};
  end

endmodule

// ==== testbench/kdi_tb.sv ====
// Testbench for the key derivation block with digest and EDN models and a table of requests
`timescale 1ns/1ps

module kdi_tb;

  localparam int NumSramSlots = 2;
  localparam int NumReq       = NumSramSlots + 2;
  localparam int NumRows      = 5;
  localparam int AckTimeout   = 3000;

  // One row of stimulus with seeds expanded from the tag
  typedef struct packed {
    logic [NumReq-1:0] mask;
    logic              valid;
    logic [63:0]       tag;
    logic              escalate;
  } row_t;

  logic                                 clk_i, rst_ni, kdi_en_i, escalate_en_i, fsm_err_o;
  logic                                 seed_valid_i;
  logic [kdi_pkg::SeedWidth-1:0]        flash_data_seed_i, flash_addr_seed_i;
  logic [kdi_pkg::SeedWidth/2-1:0]      sram_seed_i;
  logic                                 flash_data_req_i, flash_addr_req_i;
  logic [NumSramSlots-1:0]              sram_req_i;
  kdi_pkg::key_rsp_t                    flash_data_rsp_o, flash_addr_rsp_o;
  kdi_pkg::key_rsp_t [NumSramSlots-1:0] sram_rsp_o;
  logic                                 edn_req_o;
  logic                                 edn_ack_i = 1'b0;
  logic [kdi_pkg::EdnDataWidth-1:0]     edn_data_i = '0;
  logic                                 scrmbl_mtx_req_o;
  logic                                 scrmbl_mtx_gnt_i = 1'b0;
  kdi_pkg::scrmbl_req_t                 scrmbl_req_o;
  logic                                 scrmbl_ready_i = 1'b0;
  logic                                 scrmbl_valid_i = 1'b0;
  logic [kdi_pkg::ScrmblBlockWidth-1:0] scrmbl_data_i = '0;

  integer            seed = 32'h0c8d4e96;
  logic [63:0]       dig_state = '0;
  logic [63:0]       fin_data = '0;
  int                fin_wait = 0;
  int                edn_wait = 1;
  logic [63:0]       edn_words [$];
  logic [127:0]      exp_nonce = '0;
  logic [NumReq-1:0] req_mask = '0;
  int                rr_ptr = 0;
  int                test_errors, total_errors, tests_run, tests_failed;
  row_t              rows [NumRows];
  string             row_names [NumRows];

  kdi_top #(.NumSramSlots(NumSramSlots)) uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Digest, mutex and EDN models
  //////////////////////////////////////////////////

  always @(negedge clk_i) begin : models
    // Mutex granted as soon as it is asked for
    scrmbl_mtx_gnt_i = scrmbl_mtx_req_o;
    // Finalize result comes back after its delay
    scrmbl_valid_i = 1'b0;
    if (fin_wait > 0) begin
      fin_wait--;
      if (fin_wait == 0) begin
        scrmbl_valid_i = 1'b1;
        scrmbl_data_i  = fin_data;
      end
    end
    scrmbl_ready_i = ($unsigned($random(seed)) % 4) != 0;
    // Command is taken at the coming rising edge
    if (scrmbl_req_o.valid && scrmbl_ready_i) begin
      case (scrmbl_req_o.cmd)
        kdi_pkg::DigestInit: dig_state = digest_iv(scrmbl_req_o.sel);
        kdi_pkg::DigestFinalize: begin
          fin_data = dig_state;
          fin_wait = 1 + ($unsigned($random(seed)) % 4);
        end
        default: dig_state = dig_state ^ scrmbl_req_o.data;
      endcase
    end
    // EDN acks 1 to 3 cycles after the request
    if (edn_ack_i) begin
      edn_ack_i = 1'b0;
      edn_wait  = $unsigned($random(seed)) % 3;
    end else if (edn_req_o) begin
      if (edn_wait == 0) begin
        edn_data_i = {$random(seed), $random(seed)};
        edn_ack_i  = 1'b1;
        edn_words.push_back(edn_data_i);
      end else begin
        edn_wait--;
      end
    end
  end

  //////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////

  // Digest IV per netlist constant
  function automatic logic [63:0] digest_iv(input kdi_pkg::digest_sel_e sel);
    case (sel)
      kdi_pkg::FlashDataKey: return 64'h3a1f_92c4_d605_7be8;
      kdi_pkg::FlashAddrKey: return 64'hc0de_4d21_8f36_e579;
      default:               return 64'h6b9a_07f3_1e48_c2d5;
    endcase
  endfunction

  function automatic logic [255:0] expand_seed(input logic [63:0] tag);
    return {tag ^ 64'h5a5a_0f0f_3c3c_9696, tag + 64'd3, ~tag, {tag[31:0], tag[63:32]}};
  endfunction

  function automatic int words_needed(input int k);
    return (k == 0) ? 2 : (k == 1) ? 1 : 6;
  endfunction

  // Key halves are IV xor blocks and SRAM adds two entropy words per half
  function automatic kdi_pkg::key_rsp_t expect_rsp(input int k);
    kdi_pkg::key_rsp_t   rsp;
    kdi_pkg::digest_sel_e sel;
    logic [255:0]        blk;
    logic [63:0]         iv;
    if (k == 0) begin
      blk = flash_data_seed_i;
      sel = kdi_pkg::FlashDataKey;
    end else if (k == 1) begin
      blk = flash_addr_seed_i;
      sel = kdi_pkg::FlashAddrKey;
    end else begin
      blk = {sram_seed_i, sram_seed_i};
      sel = kdi_pkg::SramDataKey;
    end
    if (!seed_valid_i) blk = '0;
    iv             = digest_iv(sel);
    rsp.ack        = 1'b1;
    rsp.seed_valid = seed_valid_i;
    rsp.key        = {iv ^ blk[191:128] ^ blk[255:192], iv ^ blk[63:0] ^ blk[127:64]};
    if (k >= 2) begin
      rsp.key   = rsp.key ^ {edn_words[2] ^ edn_words[3], edn_words[0] ^ edn_words[1]};
      rsp.nonce = {edn_words[5], edn_words[4]};
    end else if (k == 1) begin
      // Word 1 keeps its old value
      rsp.nonce = {exp_nonce[127:64], edn_words[0]};
    end else begin
      rsp.nonce = {edn_words[1], edn_words[0]};
    end
    return rsp;
  endfunction

  // First pending requester at or after the pointer
  function automatic int next_rr(input logic [NumReq-1:0] pending);
    for (int off = 0; off < NumReq; off++) begin
      if (pending[(rr_ptr + off) % NumReq]) return (rr_ptr + off) % NumReq;
    end
    return -1;
  endfunction

  function automatic logic [NumReq-1:0] ack_vec();
    logic [NumReq-1:0] v;
    v[0] = flash_data_rsp_o.ack;
    v[1] = flash_addr_rsp_o.ack;
    for (int k = 0; k < NumSramSlots; k++) v[k+2] = sram_rsp_o[k].ack;
    return v;
  endfunction

  function automatic kdi_pkg::key_rsp_t rsp_of(input int k);
    if (k == 0) return flash_data_rsp_o;
    if (k == 1) return flash_addr_rsp_o;
    return sram_rsp_o[k-2];
  endfunction

  //////////////////////////////////////////////////
  // Checks and reporting
  //////////////////////////////////////////////////

  task automatic check_rsp(input string name, input kdi_pkg::key_rsp_t got,
                           input kdi_pkg::key_rsp_t exp);
    if (got.ack !== exp.ack) begin
      $display("FAIL t=%0t %s.ack got %b exp %b", $time, name, got.ack, exp.ack);
      test_errors++;
    end
    if (got.key !== exp.key) begin
      $display("FAIL t=%0t %s.key got %h exp %h", $time, name, got.key, exp.key);
      test_errors++;
    end
    if (got.nonce !== exp.nonce) begin
      $display("FAIL t=%0t %s.nonce got %h exp %h", $time, name, got.nonce, exp.nonce);
      test_errors++;
    end
    if (got.seed_valid !== exp.seed_valid) begin
      $display("FAIL t=%0t %s.seed_valid got %b exp %b", $time, name, got.seed_valid,
               exp.seed_valid);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL t=%0t %s got %0d exp %0d", $time, name, got, exp);
      test_errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) tests_failed++;
    $display("test %0d %s: %s", tests_run, name, (test_errors == 0) ? "pass" : "fail");
    test_errors = 0;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic drive_reqs();
    flash_data_req_i = req_mask[0];
    flash_addr_req_i = req_mask[1];
    sram_req_i       = req_mask[NumReq-1:2];
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : main
    logic [NumReq-1:0] pending, got;
    logic [255:0]      sram_full;
    kdi_pkg::key_rsp_t exp_rsp;
    int                ack_cnt [NumReq];
    int                waited, late, k_exp;
    rows[0] = '{mask: 4'b0001, valid: 1'b1, tag: 64'h0123_4567_89ab_cdef, escalate: 1'b0};
    rows[1] = '{mask: 4'b0010, valid: 1'b1, tag: 64'hfedc_ba98_7654_3210, escalate: 1'b0};
    rows[2] = '{mask: 4'b0100, valid: 1'b1, tag: 64'h1357_9bdf_2468_ace0, escalate: 1'b0};
    rows[3] = '{mask: 4'b0001, valid: 1'b0, tag: 64'h0f1e_2d3c_4b5a_6978, escalate: 1'b0};
    rows[4] = '{mask: 4'b1111, valid: 1'b1, tag: 64'h7777_aaaa_5555_cccc, escalate: 1'b1};
    row_names = '{"flash data key", "flash addr key", "sram key", "invalid seed",
                  "all clients then escalation"};
    test_errors       = 0;
    total_errors      = 0;
    tests_run         = 0;
    tests_failed      = 0;
    rst_ni            = 1'b0;
    kdi_en_i          = 1'b0;
    escalate_en_i     = 1'b0;
    seed_valid_i      = 1'b0;
    flash_data_seed_i = '0;
    flash_addr_seed_i = '0;
    sram_seed_i       = '0;
    drive_reqs();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Requests before enable must stay unanswered
    req_mask = 4'b0001;
    drive_reqs();
    repeat (10) begin
      @(negedge clk_i);
      check_count("ack vector", ack_vec(), 0);
      check_flag("edn_req_o", edn_req_o, 1'b0);
      check_flag("scrmbl_mtx_req_o", scrmbl_mtx_req_o, 1'b0);
      check_flag("scrmbl_req_o.valid", scrmbl_req_o.valid, 1'b0);
      check_flag("fsm_err_o", fsm_err_o, 1'b0);
    end
    check_rsp("flash_data_rsp_o", flash_data_rsp_o, '0);
    end_test("idle before enable");
    @(negedge clk_i);
    kdi_en_i = 1'b1;
    @(negedge clk_i);
    kdi_en_i = 1'b0;

    for (int r = 0; r < NumRows; r++) begin
      @(negedge clk_i);
      sram_full         = expand_seed(rows[r].tag ^ 64'h1111_2222_3333_4444);
      flash_data_seed_i = expand_seed(rows[r].tag);
      flash_addr_seed_i = expand_seed(~rows[r].tag);
      sram_seed_i       = sram_full[127:0];
      seed_valid_i      = rows[r].valid;
      req_mask          = rows[r].mask;
      drive_reqs();
      pending = rows[r].mask;
      for (int k = 0; k < NumReq; k++) ack_cnt[k] = 0;
      while (pending != '0) begin
        waited = 0;
        got    = '0;
        while (got == '0) begin
          @(negedge clk_i);
          waited++;
          if (waited > AckTimeout) abort_run($sformatf("timeout waiting for ack in %s",
                                                       row_names[r]));
          got = ack_vec();
        end
        check_count("ack without request", got & ~pending, 0);
        for (int k = 0; k < NumReq; k++) begin
          if (got[k]) ack_cnt[k]++;
          if (got[k] && pending[k]) begin
            k_exp = next_rr(pending);
            check_count("grant order", k, k_exp);
            check_count("EDN words", edn_words.size(), words_needed(k));
            if (edn_words.size() == words_needed(k)) begin
              exp_rsp = expect_rsp(k);
              check_rsp($sformatf("rsp[%0d]", k), rsp_of(k), exp_rsp);
              exp_nonce = exp_rsp.nonce;
            end
            edn_words.delete();
            rr_ptr      = (k + 1) % NumReq;
            pending[k]  = 1'b0;
            req_mask[k] = 1'b0;
          end
        end
        drive_reqs();
      end
      for (int k = 0; k < NumReq; k++) begin
        check_count($sformatf("acks of requester %0d", k), ack_cnt[k], rows[r].mask[k]);
      end

      // Escalation with a client still asking
      if (rows[r].escalate) begin
        @(negedge clk_i);
        escalate_en_i = 1'b1;
        req_mask      = 4'b0001;
        drive_reqs();
        waited = 0;
        while (!fsm_err_o) begin
          @(negedge clk_i);
          waited++;
          if (waited > 20) abort_run("fsm_err_o did not rise after escalation");
        end
        late = 0;
        repeat (AckTimeout / 10) begin
          @(negedge clk_i);
          if (ack_vec() != '0) late++;
          check_flag("fsm_err_o", fsm_err_o, 1'b1);
        end
        check_count("acks after escalation", late, 0);
      end
      end_test(row_names[r]);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
common/kdi_pkg.sv
kdi/kdi_req_arbiter.sv
kdi/kdi_fsm.sv
kdi/kdi_key_regs.sv
verilog/kdi_top.sv
testbench/kdi_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= kdi_tb
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
PASS_MSG  := TEST OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
